//--- rtl/uart_bridge_pkg.sv
package uart_bridge_pkg;

  // Opcode bytes as they arrive on the serial line
  typedef enum logic [7:0] {
    OP_READ  = 8'h52,  // 'R', opcode then address
    OP_WRITE = 8'h57   // 'W', opcode, address, then data
  } opcode_e;

  // Decoded command, decoder to register bank
  typedef struct packed {
    opcode_e    op;
    logic [3:0] addr;
    logic [7:0] wdata;  // Zero for reads
  } bridge_cmd_t;

  // One reply byte towards the transmitter
  typedef struct packed {
    logic [7:0] data;
  } bridge_resp_t;

  // Reply bytes
  localparam logic [7:0] ACK_BYTE = 8'h06;
  localparam logic [7:0] NAK_BYTE = 8'h15;

  // Register file size, addresses wrap at this count
  localparam int REG_COUNT = 16;

endpackage

//--- rtl/uart_receiver.sv
`timescale 1ns/100ps

module uart_receiver #(
  parameter logic [15:0] WTIME = 16'h28B0
) (
  input  logic       clk,
  input  logic       nrst,
  input  logic       rx_i,
  output logic       byte_valid_o,
  output logic [7:0] byte_data_o
);

  typedef enum logic {
    RX_SLEEP,
    RX_RUN
  } rx_state_e;

  rx_state_e   state;
  logic        rx_meta;
  logic        rx_sync;
  logic [15:0] counter;
  logic [3:0]  index;    // 0 start, 1..8 data, 9 stop
  logic [7:0]  shift_buf;
  logic        bit_tick;
  logic        data_bit;
  logic        stop_ok;

  // Counter hits zero near the middle of each bit
  assign bit_tick = (state == RX_RUN) && (counter == 16'd0);
  assign data_bit = (index >= 4'd1) && (index <= 4'd8);
  assign stop_ok  = bit_tick && (index == 4'd9) && rx_sync;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      rx_meta      <= 1'b1;
      rx_sync      <= 1'b1;
      state        <= RX_SLEEP;
      counter      <= '0;
      index        <= '0;
      byte_valid_o <= 1'b0;
    end else begin
      rx_meta      <= rx_i;
      rx_sync      <= rx_meta;
      byte_valid_o <= stop_ok;

      case (state)
        RX_SLEEP: begin
          if (!rx_sync) begin  // Falling start edge
            state   <= RX_RUN;
            counter <= {1'b0, WTIME[15:1]};
            index   <= '0;
          end
        end
        RX_RUN: begin
          if (bit_tick) begin
            counter <= WTIME - 16'd1;
            index   <= index + 4'd1;
            // Stop bit done, or start bit was only a glitch
            if ((index == 4'd9) || ((index == 4'd0) && rx_sync)) begin
              state <= RX_SLEEP;
            end
          end else begin
            counter <= counter - 16'd1;
          end
        end
        default: state <= RX_SLEEP;
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clk) begin
    if (bit_tick && data_bit) begin
      shift_buf <= {rx_sync, shift_buf[7:1]};
    end
    if (stop_ok) begin
      byte_data_o <= shift_buf;
    end
  end

endmodule

//--- rtl/command_decoder.sv
`timescale 1ns/100ps

module command_decoder (
  input  logic                        clk,
  input  logic                        nrst,
  input  logic                        byte_valid_i,
  input  logic [7:0]                  byte_data_i,
  output logic                        cmd_valid_o,
  output uart_bridge_pkg::bridge_cmd_t cmd_o,
  output logic                        nak_valid_o
);

  typedef enum logic [1:0] {
    DEC_WAIT_OP,
    DEC_WAIT_ADDR,
    DEC_WAIT_DATA
  } dec_state_e;

  dec_state_e                state;
  uart_bridge_pkg::opcode_e  op_q;
  logic [3:0]                addr_q;
  logic                      op_legal;
  logic                      op_byte;
  logic                      cmd_done;

  assign op_legal = (byte_data_i == uart_bridge_pkg::OP_WRITE) ||
                    (byte_data_i == uart_bridge_pkg::OP_READ);
  assign op_byte  = byte_valid_i && (state == DEC_WAIT_OP);

  // Address completes a read, data completes a write
  assign cmd_done = byte_valid_i &&
                    (((state == DEC_WAIT_ADDR) && (op_q == uart_bridge_pkg::OP_READ)) ||
                     (state == DEC_WAIT_DATA));

  always_ff @(posedge clk) begin
    if (!nrst) begin
      state       <= DEC_WAIT_OP;
      cmd_valid_o <= 1'b0;
      nak_valid_o <= 1'b0;
    end else begin
      cmd_valid_o <= cmd_done;
      nak_valid_o <= op_byte && !op_legal;  // Refused at once
      if (byte_valid_i) begin
        case (state)
          DEC_WAIT_OP: begin
            if (op_legal) begin
              state <= DEC_WAIT_ADDR;
            end
          end
          DEC_WAIT_ADDR: begin
            state <= (op_q == uart_bridge_pkg::OP_WRITE) ? DEC_WAIT_DATA : DEC_WAIT_OP;
          end
          DEC_WAIT_DATA: state <= DEC_WAIT_OP;
          default:       state <= DEC_WAIT_OP;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (op_byte && op_legal) begin
      op_q <= uart_bridge_pkg::opcode_e'(byte_data_i);
    end
    if (byte_valid_i && (state == DEC_WAIT_ADDR)) begin
      addr_q <= byte_data_i[3:0];  // Upper address bits ignored
    end
    if (cmd_done) begin
      cmd_o.op    <= op_q;
      cmd_o.addr  <= (state == DEC_WAIT_ADDR) ? byte_data_i[3:0] : addr_q;
      cmd_o.wdata <= (state == DEC_WAIT_DATA) ? byte_data_i : 8'h00;
    end
  end

endmodule

//--- rtl/register_bank.sv
`timescale 1ns/100ps

module register_bank (
  input  logic                          clk,
  input  logic                          nrst,
  input  logic                          cmd_valid_i,
  input  uart_bridge_pkg::bridge_cmd_t  cmd_i,
  input  logic                          nak_valid_i,
  output logic                          resp_valid_o,
  output uart_bridge_pkg::bridge_resp_t resp_o
);

  logic [7:0] regs [uart_bridge_pkg::REG_COUNT];
  logic       wr_en;

  assign wr_en = cmd_valid_i && (cmd_i.op == uart_bridge_pkg::OP_WRITE);

  always_ff @(posedge clk) begin
    if (!nrst) begin
      for (int i = 0; i < uart_bridge_pkg::REG_COUNT; i++) begin
        regs[i] <= 8'h00;
      end
      resp_valid_o <= 1'b0;
    end else begin
      if (wr_en) begin
        regs[cmd_i.addr] <= cmd_i.wdata;
      end
      resp_valid_o <= cmd_valid_i || nak_valid_i;  // Never both in one cycle
    end
  end

  // Reply byte, read data is the value before any write
  always_ff @(posedge clk) begin
    if (nak_valid_i) begin
      resp_o.data <= uart_bridge_pkg::NAK_BYTE;
    end else if (cmd_valid_i) begin
      case (cmd_i.op)
        uart_bridge_pkg::OP_WRITE: resp_o.data <= uart_bridge_pkg::ACK_BYTE;
        uart_bridge_pkg::OP_READ:  resp_o.data <= regs[cmd_i.addr];
        default:                   resp_o.data <= uart_bridge_pkg::NAK_BYTE;
      endcase
    end
  end

endmodule

//--- rtl/uart_transmitter.sv
`timescale 1ns/100ps

module uart_transmitter #(
  parameter logic [15:0] WTIME = 16'h28B0
) (
  input  logic                          clk,
  input  logic                          nrst,
  input  logic                          resp_valid_i,
  input  uart_bridge_pkg::bridge_resp_t resp_i,
  output logic                          tx_o
);

  typedef enum logic {
    TX_IDLE,
    TX_SEND
  } tx_state_e;

  tx_state_e   state;
  logic [9:0]  shift_reg;  // {stop, data, start}, bit 0 on the line
  logic [15:0] counter;
  logic [3:0]  bit_cnt;
  logic        bit_end;

  assign bit_end = (state == TX_SEND) && (counter == 16'd0);
  assign tx_o    = shift_reg[0];

  always_ff @(posedge clk) begin
    if (!nrst) begin
      state     <= TX_IDLE;
      shift_reg <= '1;  // Line idles high
      counter   <= '0;
      bit_cnt   <= '0;
    end else begin
      case (state)
        TX_IDLE: begin
          if (resp_valid_i) begin
            state     <= TX_SEND;
            shift_reg <= {1'b1, resp_i.data, 1'b0};
            counter   <= WTIME - 16'd1;
            bit_cnt   <= '0;
          end
        end
        TX_SEND: begin
          if (bit_end) begin
            shift_reg <= {1'b1, shift_reg[9:1]};  // Next bit, LSB first
            counter   <= WTIME - 16'd1;
            bit_cnt   <= bit_cnt + 4'd1;
            if (bit_cnt == 4'd9) begin
              state <= TX_IDLE;  // Stop bit complete
            end
          end else begin
            counter <= counter - 16'd1;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

endmodule

//--- rtl/uart_bridge_top.sv
`timescale 1ns/100ps

module uart_bridge_top #(
  parameter logic [15:0] WTIME = 16'h28B0  // Bit time in clock cycles
) (
  input  logic clk,
  input  logic nrst,
  input  logic rx_i,
  output logic tx_o
);

  logic                          byte_valid;
  logic [7:0]                    byte_data;
  logic                          cmd_valid;
  uart_bridge_pkg::bridge_cmd_t  cmd;
  logic                          nak_valid;
  logic                          resp_valid;
  uart_bridge_pkg::bridge_resp_t resp;

  uart_receiver #(.WTIME(WTIME)) u_receiver (
    .clk          (clk),
    .nrst         (nrst),
    .rx_i         (rx_i),
    .byte_valid_o (byte_valid),
    .byte_data_o  (byte_data)
  );

  command_decoder u_decoder (
    .clk          (clk),
    .nrst         (nrst),
    .byte_valid_i (byte_valid),
    .byte_data_i  (byte_data),
    .cmd_valid_o  (cmd_valid),
    .cmd_o        (cmd),
    .nak_valid_o  (nak_valid)
  );

  register_bank u_bank (
    .clk          (clk),
    .nrst         (nrst),
    .cmd_valid_i  (cmd_valid),
    .cmd_i        (cmd),
    .nak_valid_i  (nak_valid),
    .resp_valid_o (resp_valid),
    .resp_o       (resp)
  );

  uart_transmitter #(.WTIME(WTIME)) u_transmitter (
    .clk          (clk),
    .nrst         (nrst),
    .resp_valid_i (resp_valid),
    .resp_i       (resp),
    .tx_o         (tx_o)
  );

endmodule

//--- tb/uart_bridge_assertions.sv
`timescale 1ns/100ps

module uart_bridge_assertions (
  input logic clk,
  input logic nrst,
  input logic byte_valid_i,
  input logic cmd_valid_i,
  input logic nak_valid_i,
  input logic resp_valid_i,
  input logic tx_i
);

  int fail_count = 0;  // Failed properties so far

  // Strobes last exactly one cycle
  byte_strobe: assert property (@(posedge clk) disable iff (!nrst)
    byte_valid_i |=> !byte_valid_i)
    else begin
      $error("byte_valid high for two cycles");
      fail_count++;
    end

  cmd_strobe: assert property (@(posedge clk) disable iff (!nrst)
    cmd_valid_i |=> !cmd_valid_i)
    else begin
      $error("cmd_valid high for two cycles");
      fail_count++;
    end

  resp_strobe: assert property (@(posedge clk) disable iff (!nrst)
    resp_valid_i |=> !resp_valid_i)
    else begin
      $error("resp_valid high for two cycles");
      fail_count++;
    end

  cmd_or_nak: assert property (@(posedge clk) disable iff (!nrst)
    !(cmd_valid_i && nak_valid_i))
    else begin
      $error("cmd_valid and nak_valid high together");
      fail_count++;
    end

  // Checked mid-cycle, after the first reset edge
  tx_reset_high: assert property (@(negedge clk) !nrst |-> tx_i)
    else begin
      $error("tx_o low during reset");
      fail_count++;
    end

endmodule

bind uart_bridge_top uart_bridge_assertions u_assertions (
  .clk          (clk),
  .nrst         (nrst),
  .byte_valid_i (byte_valid),
  .cmd_valid_i  (cmd_valid),
  .nak_valid_i  (nak_valid),
  .resp_valid_i (resp_valid),
  .tx_i         (tx_o)
);

//--- tb/uart_bridge_tb.sv
`timescale 1ns/100ps

module uart_bridge_tb;

  localparam int BIT_T = 16;  // Cycles per serial bit

  logic clk;
  logic nrst;
  logic rx_i;
  logic tx_o;

  uart_bridge_pkg::bridge_resp_t exp_q[$];
  int                            sent_count   = 0;
  int                            replies_done = 0;
  logic [7:0]                    ref_regs [uart_bridge_pkg::REG_COUNT];

  uart_bridge_top #(.WTIME(16'd16)) DUT (
    .clk  (clk),
    .nrst (nrst),
    .rx_i (rx_i),
    .tx_o (tx_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_resp(input uart_bridge_pkg::bridge_resp_t exp,
                            input uart_bridge_pkg::bridge_resp_t act);
    if (act !== exp) begin
      report_failure($sformatf("error at %0t: reply expected %02h, got %02h",
                               $time, exp.data, act.data));
    end
  endtask

  task automatic check_idle(input logic line);
    if (line !== 1'b1) begin
      report_failure($sformatf("error at %0t: tx_o is %b while idle, expected 1", $time, line));
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Expected reply from the protocol rules, updates the model registers
  function automatic uart_bridge_pkg::bridge_resp_t ref_reply(input logic [7:0] op,
                                                              input logic [7:0] addr,
                                                              input logic [7:0] data);
    uart_bridge_pkg::bridge_resp_t r;
    int                            idx;
    idx = addr % uart_bridge_pkg::REG_COUNT;
    if (op == uart_bridge_pkg::OP_WRITE) begin
      ref_regs[idx] = data;
      r.data = uart_bridge_pkg::ACK_BYTE;
    end else if (op == uart_bridge_pkg::OP_READ) begin
      r.data = ref_regs[idx];
    end else begin
      r.data = uart_bridge_pkg::NAK_BYTE;
    end
    return r;
  endfunction

  // Start, 8 data bits LSB first, stop, then two idle bit times
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #1 rx_i = frame[i];
      repeat (BIT_T - 1) @(posedge clk);
    end
    @(posedge clk);
    #1 rx_i = 1'b1;
    repeat (2 * BIT_T - 1) @(posedge clk);
  endtask

  task automatic monitor_reply(output uart_bridge_pkg::bridge_resp_t resp);
    logic       prev;
    logic [9:0] frame;
    int         waited;
    waited = 0;
    do begin
      prev = tx_o;
      @(negedge clk);
      waited++;
      if (waited > 40 * BIT_T) report_failure("no reply started on tx_o within 40 bit times");
    end while (!((prev === 1'b1) && (tx_o === 1'b0)));
    repeat (BIT_T / 2) @(negedge clk);  // Middle of the start bit
    frame[0] = tx_o;
    for (int i = 1; i < 10; i++) begin
      repeat (BIT_T) @(negedge clk);
      frame[i] = tx_o;
    end
    if (frame[0] !== 1'b0) report_failure("start bit on tx_o did not stay low");
    if (frame[9] !== 1'b1) report_failure("stop bit of the reply on tx_o was low");
    resp.data = frame[8:1];
  endtask

  task automatic wait_replies();
    int waited;
    waited = 0;
    while (replies_done < sent_count) begin
      @(negedge clk);
      waited++;
      if (waited > 40 * BIT_T) report_failure("reply was not received in time");
    end
  endtask

  task automatic run_cmd(input logic [7:0] op, input logic [7:0] addr, input logic [7:0] data);
    exp_q.push_back(ref_reply(op, addr, data));
    sent_count++;
    send_byte(op);
    if ((op == uart_bridge_pkg::OP_WRITE) || (op == uart_bridge_pkg::OP_READ)) send_byte(addr);
    if (op == uart_bridge_pkg::OP_WRITE) send_byte(data);
    wait_replies();
  endtask

  // Any failed bound assertion ends the run
  always @(negedge clk) begin
    if (DUT.u_assertions.fail_count != 0) begin
      report_failure("a bound assertion on the strobes or tx_o failed");
    end
  end

  initial begin : compare_replies
    uart_bridge_pkg::bridge_resp_t got;
    int                            waited;
    waited = 0;
    while (nrst !== 1'b1) begin
      @(negedge clk);
      waited++;
      if (waited > 100) report_failure("reset was never released");
    end
    forever begin
      monitor_reply(got);
      if (exp_q.size() == 0) begin
        report_failure("reply on tx_o with no command pending");
      end else begin
        check_resp(exp_q.pop_front(), got);
        replies_done++;
      end
    end
  end

  initial begin : stimulus
    logic [31:0] rng;
    logic [7:0]  op;
    nrst = 1'b0;
    rx_i = 1'b1;
    rng  = 32'd27;
    for (int i = 0; i < uart_bridge_pkg::REG_COUNT; i++) begin
      ref_regs[i] = 8'h00;
    end
    repeat (5) @(posedge clk);
    #1 nrst = 1'b1;

    for (int i = 0; i < 10 * BIT_T; i++) begin  // Quiet line after reset
      @(negedge clk);
      check_idle(tx_o);
    end
    run_cmd(uart_bridge_pkg::OP_READ, 8'h03, 8'h00);

    run_cmd(uart_bridge_pkg::OP_WRITE, 8'h05, 8'hA7);
    run_cmd(uart_bridge_pkg::OP_READ, 8'h05, 8'h00);

    run_cmd(uart_bridge_pkg::OP_WRITE, 8'h25, 8'h3C);  // Wraps onto register 5
    run_cmd(uart_bridge_pkg::OP_READ, 8'h05, 8'h00);

    run_cmd(8'h41, 8'h00, 8'h00);
    run_cmd(uart_bridge_pkg::OP_WRITE, 8'h0A, 8'h5E);
    run_cmd(uart_bridge_pkg::OP_READ, 8'h0A, 8'h00);

    for (int n = 0; n < 200; n++) begin
      rng = xorshift32(rng);
      case (rng[1:0])
        2'd0, 2'd1: op = uart_bridge_pkg::OP_WRITE;
        2'd2:       op = uart_bridge_pkg::OP_READ;
        default: begin
          op = rng[15:8];
          if ((op == uart_bridge_pkg::OP_WRITE) || (op == uart_bridge_pkg::OP_READ)) begin
            op = op ^ 8'h80;
          end
        end
      endcase
      run_cmd(op, rng[23:16], rng[31:24]);
    end

    if (DUT.u_assertions.fail_count != 0) begin
      report_failure("a bound assertion failed during the test");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

//--- filelist.f
rtl/uart_bridge_pkg.sv
rtl/uart_receiver.sv
rtl/command_decoder.sv
rtl/register_bank.sv
rtl/uart_transmitter.sv
rtl/uart_bridge_top.sv
tb/uart_bridge_assertions.sv
tb/uart_bridge_tb.sv

//--- Bender.yml
package:
  name: uart_bridge

sources:
  - files:
      - rtl/uart_bridge_pkg.sv
      - rtl/uart_receiver.sv
      - rtl/command_decoder.sv
      - rtl/register_bank.sv
      - rtl/uart_transmitter.sv
      - rtl/uart_bridge_top.sv
  - target: simulation
    files:
      - tb/uart_bridge_assertions.sv
      - tb/uart_bridge_tb.sv
